/* rtl/a8_io_defs.svh */
/*
 * Sizing macros for the Atari 800 I/O block
 *   Sector buffer address width and depth
 *   Host storage slot count and cartridge slot
 *   Joystick width, mouse step and paddle clamp limits
 */
`ifndef A8_IO_DEFS_SVH
`define A8_IO_DEFS_SVH

// ================================================
// Disk bridge
// ================================================

// 512-byte sector buffer
`define A8_BUF_ADDR_W 9
`define A8_BUF_DEPTH (1 << `A8_BUF_ADDR_W)

// Slots 0 and 1 are drives, the last one is the cartridge
`define A8_NUM_SLOTS 3
`define A8_CART_SLOT 2

// ================================================
// Controller ports
// ================================================

`define A8_JOY_W 14

// Largest mouse step after halving
`define A8_MOUSE_STEP_MAX 10

// Paddle position range
`define A8_AXIS_MIN (-128)
`define A8_AXIS_MAX 127

`endif

/* rtl/a8_io_pkg.sv */
/*
 * Shared vector types of the Atari 800 I/O block
 *   Bus bytes and words, buffer address
 *   Slot masks and indices, drive number
 *   Joystick state, paddle position, mouse packet
 */
`default_nettype none

`include "a8_io_defs.svh"

package a8_io_pkg;

	// Buffer data or status byte
	typedef logic [7:0] byte_t;

	// Processor data word, sector address, file size
	typedef logic [31:0] word_t;

	typedef logic [`A8_BUF_ADDR_W-1:0] buf_addr_t;

	// One bit per host storage slot
	typedef logic [`A8_NUM_SLOTS-1:0] slot_mask_t;
	typedef logic [$clog2(`A8_NUM_SLOTS)-1:0] slot_idx_t;

	// Drive number as written by the processor
	typedef logic [2:0] drive_num_t;

	typedef logic [`A8_JOY_W-1:0] joy_t;

	// Signed paddle position
	typedef logic signed [7:0] axis_t;

	// Mouse packet
	//   24 toggle, 23..16 Y move, 15..8 X move
	//   5 Y sign, 4 X sign, 1..0 buttons
	typedef logic [24:0] mouse_pkt_t;

endpackage

`default_nettype wire

/* rtl/sector_buffer.sv */
/*
 * Dual-port sector memory
 *   Port a serves the host storage side
 *   Port b serves the processor side
 *   Registered read data on both ports
 */
`default_nettype none

`include "a8_io_defs.svh"

module sector_buffer (
	input  wire logic                clk_sys,

	input  wire a8_io_pkg::buf_addr_t a_addr_i,
	input  wire a8_io_pkg::byte_t     a_data_i,
	input  wire logic                a_wr_i,
	output a8_io_pkg::byte_t          a_data_o,

	input  wire a8_io_pkg::buf_addr_t b_addr_i,
	input  wire a8_io_pkg::byte_t     b_data_i,
	input  wire logic                b_wr_i,
	output a8_io_pkg::byte_t          b_data_o
);

	// Contents are undefined until written
	a8_io_pkg::byte_t mem [`A8_BUF_DEPTH];

	// ================================================
	// Host port
	// ================================================

	always @(posedge clk_sys) begin
		if (a_wr_i) begin
			mem[a_addr_i] <= a_data_i;
		end
		a_data_o <= mem[a_addr_i];
	end

	// ================================================
	// Processor port
	// ================================================

	always @(posedge clk_sys) begin
		if (b_wr_i) begin
			mem[b_addr_i] <= b_data_i;
		end
		b_data_o <= mem[b_addr_i];
	end

endmodule

`default_nettype wire

/* rtl/disk_bridge.sv */
/*
 * Disk bridge between the I/O processor and host storage
 *   Processor buffer address and sector address registers
 *   Block read and write requests with acknowledge tracking
 *   Mount status byte and file size
 *   Shared sector buffer instance
 */
`default_nettype none

`include "a8_io_defs.svh"

module disk_bridge (
	input  wire logic                  clk_sys,
	input  wire logic                  areset,

	// Processor side
	input  wire logic                  lba_sel_i,
	input  wire logic                  block_rd_i,
	input  wire logic                  block_wr_i,
	input  wire a8_io_pkg::drive_num_t drive_num_i,
	input  wire a8_io_pkg::word_t      data_i,
	input  wire logic                  io_start_i,
	input  wire logic                  data_wr_i,
	input  wire logic                  data_rd_i,
	output a8_io_pkg::byte_t            status_o,
	output a8_io_pkg::word_t            data_o,

	// Host storage side
	output a8_io_pkg::word_t            sd_lba_o,
	output a8_io_pkg::slot_mask_t       sd_rd_o,
	output a8_io_pkg::slot_mask_t       sd_wr_o,
	input  wire a8_io_pkg::slot_mask_t sd_ack_i,
	input  wire a8_io_pkg::buf_addr_t  sd_buff_addr_i,
	input  wire a8_io_pkg::byte_t      sd_buff_dout_i,
	input  wire logic                  sd_buff_wr_i,
	output a8_io_pkg::byte_t            sd_buff_din_o,
	input  wire a8_io_pkg::slot_mask_t img_mounted_i,
	input  wire logic                  img_readonly_i,
	input  wire a8_io_pkg::word_t      img_size_i,
	input  wire logic [1:0]            img_type_i
);

	a8_io_pkg::buf_addr_t  buf_addr;
	a8_io_pkg::byte_t      buf_q;
	logic                  buf_wr;

	a8_io_pkg::word_t      sd_lba;
	a8_io_pkg::word_t      file_size;
	a8_io_pkg::slot_mask_t sd_rd;
	a8_io_pkg::slot_mask_t sd_wr;
	a8_io_pkg::slot_idx_t  req_slot;
	a8_io_pkg::slot_mask_t req_mask;

	logic                  io_done;
	logic                  mount_tog;
	logic                  read_only;
	logic [2:0]            file_no;
	logic [1:0]            file_type;

	// Previous levels for edge detection
	logic                  blk_rd_q;
	logic                  blk_wr_q;
	logic                  ack_q;

	// ================================================
	// Processor buffer access
	// ================================================

	assign buf_wr = data_wr_i & ~lba_sel_i;

	// Rewind wins over any increment
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			buf_addr <= '0;
		end else if (io_start_i) begin
			buf_addr <= '0;
		end else if (buf_wr || data_rd_i) begin
			buf_addr <= buf_addr + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_wr_i && lba_sel_i) begin
			sd_lba <= data_i;
		end
	end

	sector_buffer u_sector_buffer (
		.clk_sys  (clk_sys),
		.a_addr_i (sd_buff_addr_i),
		.a_data_i (sd_buff_dout_i),
		.a_wr_i   (sd_buff_wr_i),
		.a_data_o (sd_buff_din_o),
		.b_addr_i (buf_addr),
		.b_data_i (data_i[7:0]),
		.b_wr_i   (buf_wr),
		.b_data_o (buf_q)
	);

	// ================================================
	// Block requests
	// ================================================

	// Slot index 3 falls outside the mask and raises nothing
	assign req_slot = {drive_num_i[2], drive_num_i[0]};
	assign req_mask = a8_io_pkg::slot_mask_t'(1) << req_slot;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sd_rd    <= '0;
			sd_wr    <= '0;
			io_done  <= 1'b0;
			blk_rd_q <= 1'b0;
			blk_wr_q <= 1'b0;
			ack_q    <= 1'b0;
		end else begin
			blk_rd_q <= block_rd_i;
			blk_wr_q <= block_wr_i;
			ack_q    <= |sd_ack_i;

			if (block_rd_i && !blk_rd_q) begin
				sd_rd   <= sd_rd | req_mask;
				io_done <= 1'b1;
			end
			if (block_wr_i && !blk_wr_q) begin
				sd_wr   <= sd_wr | req_mask;
				io_done <= 1'b1;
			end

			// Acknowledge drops every pending request
			if (|sd_ack_i) begin
				sd_rd <= '0;
				sd_wr <= '0;
			end

			// Transfer finished
			if (ack_q && !(|sd_ack_i)) begin
				io_done <= 1'b1;
			end
		end
	end

	// ================================================
	// Mount status
	// ================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mount_tog <= 1'b0;
		end else if (|img_mounted_i) begin
			mount_tog <= ~mount_tog;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (|img_mounted_i) begin
			if (img_mounted_i[`A8_CART_SLOT]) begin
				file_no <= 3'd4;
			end else if (img_mounted_i[1]) begin
				file_no <= 3'd1;
			end else begin
				file_no <= 3'd0;
			end
			file_type <= img_type_i;
			// Cartridge image is never writable
			read_only <= img_readonly_i | img_mounted_i[`A8_CART_SLOT];
			file_size <= img_size_i;
		end
	end

	// ================================================
	// Outputs
	// ================================================

	assign status_o = {read_only, file_type, file_no, mount_tog, io_done};
	assign data_o   = lba_sel_i ? file_size : {24'd0, buf_q};
	assign sd_lba_o = sd_lba;
	assign sd_rd_o  = sd_rd;
	assign sd_wr_o  = sd_wr;

	// The processor never mixes a read and a write in one transfer
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (areset)
		!((|sd_rd_o) && (|sd_wr_o)));

	a_req_onehot: assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0(sd_rd_o) && $onehot0(sd_wr_o));

endmodule

`default_nettype wire

/* rtl/controller_ports.sv */
/*
 * Controller port logic
 *   Mouse packets accumulated into clamped paddle positions
 *   Mouse emulation enable and button substitution
 *   Controller port swap
 */
`default_nettype none

`include "a8_io_defs.svh"

module controller_ports (
	input  wire logic                  clk_sys,
	input  wire logic                  areset,

	input  wire a8_io_pkg::mouse_pkt_t mouse_i,
	input  wire a8_io_pkg::axis_t      analog0_x_i,
	input  wire a8_io_pkg::axis_t      analog0_y_i,
	input  wire a8_io_pkg::axis_t      analog1_x_i,
	input  wire a8_io_pkg::axis_t      analog1_y_i,
	input  wire a8_io_pkg::joy_t       joy0_i,
	input  wire a8_io_pkg::joy_t       joy1_i,
	input  wire logic                  swap_i,
	input  wire logic                  cpu_halt_i,

	output a8_io_pkg::joy_t             port1_joy_o,
	output a8_io_pkg::joy_t             port2_joy_o,
	output a8_io_pkg::axis_t            port1_x_o,
	output a8_io_pkg::axis_t            port1_y_o,
	output a8_io_pkg::axis_t            port2_x_o,
	output a8_io_pkg::axis_t            port2_y_o
);

	a8_io_pkg::axis_t mouse_x;
	a8_io_pkg::axis_t mouse_y;
	a8_io_pkg::axis_t mouse_x_next;
	a8_io_pkg::axis_t mouse_y_next;
	logic             emu_active;
	logic             mouse_tog_q;
	logic             stick_active;

	// Stick 0 as seen before the swap
	a8_io_pkg::axis_t p0_x;
	a8_io_pkg::axis_t p0_y;
	a8_io_pkg::joy_t  p0_joy;

	// Halve the move, limit the step, then clamp the sum to the axis range
	function automatic a8_io_pkg::axis_t mouse_axis_step(
		input a8_io_pkg::axis_t pos,
		input logic             sgn,
		input a8_io_pkg::byte_t move
	);
		logic signed [8:0] step;
		logic signed [8:0] sum;

		step = {sgn, sgn, move[7:1]};
		if (step > `A8_MOUSE_STEP_MAX) begin
			step = 9'(`A8_MOUSE_STEP_MAX);
		end else if (step < -(`A8_MOUSE_STEP_MAX)) begin
			step = 9'(-(`A8_MOUSE_STEP_MAX));
		end
		sum = $signed({pos[7], pos}) + step;
		if (sum > `A8_AXIS_MAX) begin
			return a8_io_pkg::axis_t'(`A8_AXIS_MAX);
		end
		if (sum < `A8_AXIS_MIN) begin
			return a8_io_pkg::axis_t'(`A8_AXIS_MIN);
		end
		return sum[7:0];
	endfunction

	// ================================================
	// Mouse accumulation
	// ================================================

	assign mouse_x_next = mouse_axis_step(mouse_x, mouse_i[4], mouse_i[15:8]);
	assign mouse_y_next = mouse_axis_step(mouse_y, mouse_i[5], mouse_i[23:16]);
	assign stick_active = (analog0_x_i != '0) || (analog0_y_i != '0);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			emu_active  <= 1'b0;
			mouse_x     <= '0;
			mouse_y     <= '0;
			mouse_tog_q <= mouse_i[24];
		end else begin
			mouse_tog_q <= mouse_i[24];
			// Real stick or halted CPU takes the port back
			if (stick_active || cpu_halt_i) begin
				emu_active <= 1'b0;
				mouse_x    <= '0;
				mouse_y    <= '0;
			end else if (mouse_i[24] != mouse_tog_q) begin
				emu_active <= 1'b1;
				mouse_x    <= mouse_x_next;
				mouse_y    <= mouse_y_next;
			end
		end
	end

	// ================================================
	// Port muxing
	// ================================================

	// Mouse buttons stand in for fire buttons 2 and 3
	assign p0_x   = emu_active ? mouse_x : analog0_x_i;
	assign p0_y   = emu_active ? mouse_y : analog0_y_i;
	assign p0_joy = {joy0_i[13:9], emu_active ? mouse_i[1:0] : joy0_i[8:7], joy0_i[6:0]};

	assign port1_x_o   = swap_i ? analog1_x_i : p0_x;
	assign port1_y_o   = swap_i ? analog1_y_i : p0_y;
	assign port1_joy_o = swap_i ? joy1_i : p0_joy;
	assign port2_x_o   = swap_i ? p0_x : analog1_x_i;
	assign port2_y_o   = swap_i ? p0_y : analog1_y_i;
	assign port2_joy_o = swap_i ? p0_joy : joy1_i;

	// A packet moves each position by no more than one limited step
	a_step_x: assert property (@(posedge clk_sys) disable iff (areset)
		(mouse_i[24] != mouse_tog_q) && !stick_active && !cpu_halt_i
		|=> (mouse_x - $past(mouse_x) <= `A8_MOUSE_STEP_MAX)
			&& (mouse_x - $past(mouse_x) >= -(`A8_MOUSE_STEP_MAX)));

	a_step_y: assert property (@(posedge clk_sys) disable iff (areset)
		(mouse_i[24] != mouse_tog_q) && !stick_active && !cpu_halt_i
		|=> (mouse_y - $past(mouse_y) <= `A8_MOUSE_STEP_MAX)
			&& (mouse_y - $past(mouse_y) >= -(`A8_MOUSE_STEP_MAX)));

endmodule

`default_nettype wire

/* rtl/a8_io_top.sv */
/*
 * Atari 800 I/O block top level
 *   Disk bridge and controller port instances
 */
`default_nettype none

module a8_io_top (
	input  wire logic                  clk_sys,
	input  wire logic                  areset,

	// ================================================
	// Disk bridge
	// ================================================
	input  wire logic                  lba_sel_i,
	input  wire logic                  block_rd_i,
	input  wire logic                  block_wr_i,
	input  wire a8_io_pkg::drive_num_t drive_num_i,
	input  wire a8_io_pkg::word_t      data_i,
	input  wire logic                  io_start_i,
	input  wire logic                  data_wr_i,
	input  wire logic                  data_rd_i,
	output a8_io_pkg::byte_t            status_o,
	output a8_io_pkg::word_t            data_o,
	output a8_io_pkg::word_t            sd_lba_o,
	output a8_io_pkg::slot_mask_t       sd_rd_o,
	output a8_io_pkg::slot_mask_t       sd_wr_o,
	input  wire a8_io_pkg::slot_mask_t sd_ack_i,
	input  wire a8_io_pkg::buf_addr_t  sd_buff_addr_i,
	input  wire a8_io_pkg::byte_t      sd_buff_dout_i,
	input  wire logic                  sd_buff_wr_i,
	output a8_io_pkg::byte_t            sd_buff_din_o,
	input  wire a8_io_pkg::slot_mask_t img_mounted_i,
	input  wire logic                  img_readonly_i,
	input  wire a8_io_pkg::word_t      img_size_i,
	input  wire logic [1:0]            img_type_i,

	// ================================================
	// Controller ports
	// ================================================
	input  wire a8_io_pkg::mouse_pkt_t mouse_i,
	input  wire a8_io_pkg::axis_t      analog0_x_i,
	input  wire a8_io_pkg::axis_t      analog0_y_i,
	input  wire a8_io_pkg::axis_t      analog1_x_i,
	input  wire a8_io_pkg::axis_t      analog1_y_i,
	input  wire a8_io_pkg::joy_t       joy0_i,
	input  wire a8_io_pkg::joy_t       joy1_i,
	input  wire logic                  swap_i,
	input  wire logic                  cpu_halt_i,
	output a8_io_pkg::joy_t             port1_joy_o,
	output a8_io_pkg::joy_t             port2_joy_o,
	output a8_io_pkg::axis_t            port1_x_o,
	output a8_io_pkg::axis_t            port1_y_o,
	output a8_io_pkg::axis_t            port2_x_o,
	output a8_io_pkg::axis_t            port2_y_o
);

	disk_bridge u_disk_bridge (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.lba_sel_i      (lba_sel_i),
		.block_rd_i     (block_rd_i),
		.block_wr_i     (block_wr_i),
		.drive_num_i    (drive_num_i),
		.data_i         (data_i),
		.io_start_i     (io_start_i),
		.data_wr_i      (data_wr_i),
		.data_rd_i      (data_rd_i),
		.status_o       (status_o),
		.data_o         (data_o),
		.sd_lba_o       (sd_lba_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.sd_ack_i       (sd_ack_i),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.sd_buff_din_o  (sd_buff_din_o),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i)
	);

	controller_ports u_controller_ports (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.mouse_i     (mouse_i),
		.analog0_x_i (analog0_x_i),
		.analog0_y_i (analog0_y_i),
		.analog1_x_i (analog1_x_i),
		.analog1_y_i (analog1_y_i),
		.joy0_i      (joy0_i),
		.joy1_i      (joy1_i),
		.swap_i      (swap_i),
		.cpu_halt_i  (cpu_halt_i),
		.port1_joy_o (port1_joy_o),
		.port2_joy_o (port2_joy_o),
		.port1_x_o   (port1_x_o),
		.port1_y_o   (port1_y_o),
		.port2_x_o   (port2_x_o),
		.port2_y_o   (port2_y_o)
	);

endmodule

`default_nettype wire

/* tests/tb_checks.svh */
/*
 * Testbench compare tasks
 *   Pass and fail counters
 *   One compare task per DUT result type
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int pass_cnt = 0;
int fail_cnt = 0;

task automatic check_byte(input string name, input a8_io_pkg::byte_t got,
		input a8_io_pkg::byte_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		fail_cnt++;
	end else begin
		pass_cnt++;
	end
endtask

task automatic check_word(input string name, input a8_io_pkg::word_t got,
		input a8_io_pkg::word_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		fail_cnt++;
	end else begin
		pass_cnt++;
	end
endtask

task automatic check_mask(input string name, input a8_io_pkg::slot_mask_t got,
		input a8_io_pkg::slot_mask_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		fail_cnt++;
	end else begin
		pass_cnt++;
	end
endtask

task automatic check_axis(input string name, input a8_io_pkg::axis_t got,
		input a8_io_pkg::axis_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		fail_cnt++;
	end else begin
		pass_cnt++;
	end
endtask

task automatic check_joy(input string name, input a8_io_pkg::joy_t got,
		input a8_io_pkg::joy_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		fail_cnt++;
	end else begin
		pass_cnt++;
	end
endtask

`endif

/* tests/tb_a8_io.sv */
/*
 * Testbench for the Atari 800 I/O block
 *   Clock, reset and watchdog
 *   Buffer, status and mouse position models
 *   Six tests driven from a seeded random source
 */
`default_nettype none

`include "a8_io_defs.svh"

module tb_a8_io;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 8;
	localparam int CPU_BYTES    = 64;
	localparam int HOST_BYTES   = 128;
	localparam int MOUSE_PKTS   = 64;
	// Approximate cycles per test
	localparam int T1_CYCLES = 12;
	localparam int T2_CYCLES = 2 * CPU_BYTES + 2;
	localparam int T3_CYCLES = 4 * HOST_BYTES + 2;
	localparam int T4_CYCLES = 60;
	localparam int T5_CYCLES = 6;
	localparam int T6_CYCLES = MOUSE_PKTS + 10;
	localparam int RUN_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
		+ T4_CYCLES + T5_CYCLES + T6_CYCLES;

	logic clk_sys;
	logic areset;
	logic lba_sel_i, block_rd_i, block_wr_i;
	logic io_start_i, data_wr_i, data_rd_i;
	a8_io_pkg::drive_num_t drive_num_i;
	a8_io_pkg::word_t data_i, data_o, sd_lba_o, img_size_i;
	a8_io_pkg::byte_t status_o, sd_buff_dout_i, sd_buff_din_o;
	a8_io_pkg::slot_mask_t sd_rd_o, sd_wr_o, sd_ack_i, img_mounted_i;
	a8_io_pkg::buf_addr_t sd_buff_addr_i;
	logic sd_buff_wr_i, img_readonly_i;
	logic [1:0] img_type_i;
	a8_io_pkg::mouse_pkt_t mouse_i;
	a8_io_pkg::axis_t analog0_x_i, analog0_y_i, analog1_x_i, analog1_y_i;
	a8_io_pkg::axis_t port1_x_o, port1_y_o, port2_x_o, port2_y_o;
	a8_io_pkg::joy_t joy0_i, joy1_i, port1_joy_o, port2_joy_o;
	logic swap_i, cpu_halt_i;

	// Reference models
	a8_io_pkg::byte_t buf_model [`A8_BUF_DEPTH];
	a8_io_pkg::byte_t status_model;
	int mouse_x_model;
	int mouse_y_model;
	logic mouse_tog;

	integer seed;
	int test_pass0;
	int test_fail0;

	`include "tb_checks.svh"

	a8_io_top dut0 (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	initial begin
		#(6 * RUN_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", 6 * RUN_CYCLES);
		$display("Test failures found");
		$finish;
	end

	// ================================================
	// Helpers
	// ================================================

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic int clamp_int(input int v, input int lo, input int hi);
		if (v > hi) begin
			return hi;
		end
		if (v < lo) begin
			return lo;
		end
		return v;
	endfunction

	// Nine-bit signed move halved with rounding down, then limited
	function automatic int mouse_move(input int pos, input logic sgn, input a8_io_pkg::byte_t mv);
		int delta;
		delta = (sgn ? int'(mv) - 256 : int'(mv)) >>> 1;
		delta = clamp_int(delta, -`A8_MOUSE_STEP_MAX, `A8_MOUSE_STEP_MAX);
		return clamp_int(pos + delta, `A8_AXIS_MIN, `A8_AXIS_MAX);
	endfunction

	// Inputs change a short delay after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic begin_test();
		test_pass0 = pass_cnt;
		test_fail0 = fail_cnt;
	endtask

	task automatic end_test(input string name);
		$display("%s done: %0d checks, %0d errors", name,
			pass_cnt + fail_cnt - test_pass0 - test_fail0, fail_cnt - test_fail0);
	endtask

	task automatic init_inputs();
		clk_sys = 1'b0;
		areset = 1'b1;
		lba_sel_i = 1'b0;
		block_rd_i = 1'b0;
		block_wr_i = 1'b0;
		drive_num_i = '0;
		data_i = '0;
		io_start_i = 1'b0;
		data_wr_i = 1'b0;
		data_rd_i = 1'b0;
		sd_ack_i = '0;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i = 1'b0;
		img_mounted_i = '0;
		img_readonly_i = 1'b0;
		img_size_i = '0;
		img_type_i = '0;
		mouse_i = '0;
		analog0_x_i = '0;
		analog0_y_i = '0;
		analog1_x_i = '0;
		analog1_y_i = '0;
		joy0_i = '0;
		joy1_i = '0;
		swap_i = 1'b0;
		cpu_halt_i = 1'b0;
		status_model = '0;
		mouse_x_model = 0;
		mouse_y_model = 0;
		mouse_tog = 1'b0;
	endtask

	task automatic mount_slot(input int slot, input logic ro, input logic [1:0] ty,
			input a8_io_pkg::word_t size);
		img_mounted_i = a8_io_pkg::slot_mask_t'(1 << slot);
		img_readonly_i = ro;
		img_type_i = ty;
		img_size_i = size;
		tick();
		img_mounted_i = '0;
		status_model[1] = ~status_model[1];
		status_model[4:2] = (slot == `A8_CART_SLOT) ? 3'd4 : 3'(slot);
		status_model[6:5] = ty;
		// Cartridge image is forced read-only
		status_model[7] = ro | (slot == `A8_CART_SLOT);
	endtask

	task automatic send_packet(input logic sx);
		a8_io_pkg::byte_t mx;
		a8_io_pkg::byte_t my;
		logic sy;
		mx = a8_io_pkg::byte_t'(rand32());
		my = a8_io_pkg::byte_t'(rand32());
		sy = 1'(rand32());
		mouse_tog = ~mouse_tog;
		mouse_i = {mouse_tog, my, mx, 2'b00, sy, sx, 2'b00, 2'(rand32())};
		tick();
		mouse_x_model = mouse_move(mouse_x_model, sx, mx);
		mouse_y_model = mouse_move(mouse_y_model, sy, my);
	endtask

	task automatic check_mouse_port();
		check_axis("port1_x_o", port1_x_o, a8_io_pkg::axis_t'(mouse_x_model));
		check_axis("port1_y_o", port1_y_o, a8_io_pkg::axis_t'(mouse_y_model));
		check_joy("port1_joy_o", port1_joy_o, {joy0_i[13:9], mouse_i[1:0], joy0_i[6:0]});
		check_axis("port2_x_o", port2_x_o, analog1_x_i);
		check_joy("port2_joy_o", port2_joy_o, joy1_i);
	endtask

	// ================================================
	// Tests
	// ================================================

	task automatic addr_size_test();
		a8_io_pkg::word_t w;
		begin_test();
		check_mask("sd_rd_o", sd_rd_o, '0);
		check_mask("sd_wr_o", sd_wr_o, '0);
		check_byte("status_o low bits", status_o & 8'h03, 8'h00);
		lba_sel_i = 1'b1;
		repeat (8) begin
			w = rand32();
			data_i = w;
			data_wr_i = 1'b1;
			tick();
			data_wr_i = 1'b0;
			check_word("sd_lba_o", sd_lba_o, w);
		end
		w = rand32();
		mount_slot(0, 1'(rand32()), 2'(rand32()), w);
		#1;
		check_word("data_o", data_o, w);
		check_byte("status_o", status_o, status_model);
		lba_sel_i = 1'b0;
		end_test("address and size path");
	endtask

	task automatic cpu_write_test();
		begin_test();
		io_start_i = 1'b1;
		tick();
		io_start_i = 1'b0;
		for (int i = 0; i < CPU_BYTES; i++) begin
			data_i = rand32();
			buf_model[i] = data_i[7:0];
			data_wr_i = 1'b1;
			tick();
		end
		data_wr_i = 1'b0;
		for (int i = 0; i < CPU_BYTES; i++) begin
			sd_buff_addr_i = a8_io_pkg::buf_addr_t'(i);
			tick();
			check_byte("sd_buff_din_o", sd_buff_din_o, buf_model[i]);
		end
		end_test("processor writes, host reads");
	endtask

	task automatic host_write_test();
		begin_test();
		sd_buff_wr_i = 1'b1;
		for (int i = 0; i < HOST_BYTES; i++) begin
			sd_buff_addr_i = a8_io_pkg::buf_addr_t'(i);
			sd_buff_dout_i = a8_io_pkg::byte_t'(rand32());
			buf_model[i] = sd_buff_dout_i;
			tick();
		end
		sd_buff_wr_i = 1'b0;
		io_start_i = 1'b1;
		tick();
		io_start_i = 1'b0;
		for (int i = 0; i < HOST_BYTES; i++) begin
			repeat (2) tick();
			check_word("data_o", data_o, {24'd0, buf_model[i]});
			data_rd_i = 1'b1;
			tick();
			data_rd_i = 1'b0;
		end
		end_test("host writes, processor reads");
	endtask

	task automatic block_req_test();
		a8_io_pkg::drive_num_t dn;
		a8_io_pkg::slot_mask_t exp_mask;
		logic is_rd;
		int slot;
		begin_test();
		check_byte("status_o io_done", status_o & 8'h01, 8'h00);
		// A bare acknowledge sets io_done only once it falls
		sd_ack_i = 3'b010;
		tick();
		check_byte("status_o io_done", status_o & 8'h01, 8'h00);
		sd_ack_i = '0;
		tick();
		status_model[0] = 1'b1;
		check_byte("status_o", status_o, status_model);
		repeat (12) begin
			dn = a8_io_pkg::drive_num_t'(rand32());
			is_rd = 1'(rand32());
			// Slot index 3 names no slot
			slot = int'({dn[2], dn[0]});
			exp_mask = (slot < `A8_NUM_SLOTS) ? a8_io_pkg::slot_mask_t'(1 << slot) : '0;
			drive_num_i = dn;
			block_rd_i = is_rd;
			block_wr_i = ~is_rd;
			tick();
			check_mask("sd_rd_o", sd_rd_o, is_rd ? exp_mask : '0);
			check_mask("sd_wr_o", sd_wr_o, is_rd ? '0 : exp_mask);
			block_rd_i = 1'b0;
			block_wr_i = 1'b0;
			sd_ack_i = (exp_mask == '0) ? 3'b001 : exp_mask;
			tick();
			check_mask("sd_rd_o", sd_rd_o, '0);
			check_mask("sd_wr_o", sd_wr_o, '0);
			tick();
			sd_ack_i = '0;
			tick();
			status_model[0] = 1'b1;
			check_byte("status_o", status_o, status_model);
		end
		end_test("block requests");
	endtask

	task automatic mount_test();
		begin_test();
		for (int k = 0; k < 6; k++) begin
			mount_slot(k % `A8_NUM_SLOTS, 1'(rand32()), 2'(rand32()), rand32());
			check_byte("status_o", status_o, status_model);
		end
		end_test("mount status");
	endtask

	task automatic ctrl_port_test();
		begin_test();
		joy0_i = a8_io_pkg::joy_t'(rand32());
		joy1_i = a8_io_pkg::joy_t'(rand32());
		analog1_x_i = a8_io_pkg::axis_t'(rand32());
		analog1_y_i = a8_io_pkg::axis_t'(rand32());
		#1;
		check_axis("port1_x_o", port1_x_o, '0);
		check_joy("port1_joy_o", port1_joy_o, joy0_i);
		// X runs up into the upper limit, then down into the lower one
		for (int k = 0; k < MOUSE_PKTS; k++) begin
			send_packet(k >= MOUSE_PKTS / 2);
			check_mouse_port();
		end
		cpu_halt_i = 1'b1;
		tick();
		cpu_halt_i = 1'b0;
		mouse_x_model = 0;
		mouse_y_model = 0;
		check_axis("port1_x_o", port1_x_o, '0);
		check_joy("port1_joy_o", port1_joy_o, joy0_i);
		// Stick wins over a packet in the same cycle
		analog0_x_i = a8_io_pkg::axis_t'(rand32()) | 8'sh01;
		send_packet(1'b0);
		mouse_x_model = 0;
		mouse_y_model = 0;
		check_axis("port1_x_o", port1_x_o, analog0_x_i);
		check_joy("port1_joy_o", port1_joy_o, joy0_i);
		analog0_x_i = '0;
		#1;
		check_axis("port1_y_o", port1_y_o, '0);
		send_packet(1'(rand32()));
		check_mouse_port();
		swap_i = 1'b1;
		#1;
		check_axis("port1_x_o", port1_x_o, analog1_x_i);
		check_joy("port1_joy_o", port1_joy_o, joy1_i);
		check_axis("port2_x_o", port2_x_o, a8_io_pkg::axis_t'(mouse_x_model));
		check_axis("port2_y_o", port2_y_o, a8_io_pkg::axis_t'(mouse_y_model));
		check_joy("port2_joy_o", port2_joy_o, {joy0_i[13:9], mouse_i[1:0], joy0_i[6:0]});
		swap_i = 1'b0;
		end_test("controller ports");
	endtask

	initial begin
		seed = 32'h67b3_49be;
		init_inputs();
		repeat (RESET_CYCLES) tick();
		areset = 1'b0;
		addr_size_test();
		cpu_write_test();
		host_write_test();
		block_req_test();
		mount_test();
		ctrl_port_test();
		$display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
+incdir+tests
rtl/a8_io_pkg.sv
rtl/sector_buffer.sv
rtl/disk_bridge.sv
rtl/controller_ports.sv
rtl/a8_io_top.sv
tests/tb_a8_io.sv

/* Makefile */
# Verilator simulation of the Atari 800 I/O block

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_a8_io
FILELIST  = compile.f
BIN       = obj_dir/V$(TOP)
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
